//--- Bender.yml
package:
  name: fft8

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fft8_pkg.sv
      - hw/fft4_accum.sv
      - hw/twiddle_combine.sv
      - hw/spectrum_buffer.sv
      - hw/fft8_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/fft8_props.sv
      - verification/fft8_tb.sv

//--- filelist.f
+incdir+hw
hw/fft8_pkg.sv
hw/fft4_accum.sv
hw/twiddle_combine.sv
hw/spectrum_buffer.sv
hw/fft8_core.sv
verification/fft8_props.sv
verification/fft8_tb.sv

//--- hw/fft4_accum.sv
`timescale 1ns/1ps
`default_nettype none

module fft4_accum
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             sample_valid_i,
    input  wire fft8_pkg::sample_t sample_re_i,
    input  wire fft8_pkg::sample_t sample_im_i,
    input  wire logic [1:0]       bin_sel_i,
    output fft8_pkg::kern_t       bin_re_o,
    output fft8_pkg::kern_t       bin_im_o
);

    import fft8_pkg::*;

    // index n of the next sample, modulo 4
    logic [1:0] cnt_q;

    // running bins X[0..3]
    kern_t bin_re_q [4];
    kern_t bin_im_q [4];

    // contribution of the current sample to each bin
    kern_t term_re [4];
    kern_t term_im [4];

    // sample widened to bin width
    kern_t x_re;
    kern_t x_im;

    assign x_re = kern_t'(sample_re_i);
    assign x_im = kern_t'(sample_im_i);

    // W4^(n*k) is one of 1, -j, -1, +j
    always_comb
    begin
        for (int k = 0; k < 4; k++)
        begin
            unique case (2'(cnt_q * k))
                2'd0:
                begin
                    term_re[k] = x_re;
                    term_im[k] = x_im;
                end
                // -j rotation, (a + jb) -> b - ja
                2'd1:
                begin
                    term_re[k] = x_im;
                    term_im[k] = -x_re;
                end
                2'd2:
                begin
                    term_re[k] = -x_re;
                    term_im[k] = -x_im;
                end
                // +j rotation, (a + jb) -> -b + ja
                default:
                begin
                    term_re[k] = -x_im;
                    term_im[k] = x_re;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt_q <= '0;
        end
        else if (sample_valid_i)
        begin
            cnt_q <= cnt_q + 2'd1;
        end
    end

    // first sample of a frame overwrites, the other three accumulate
    always_ff @(posedge clk)
    begin
        if (sample_valid_i)
        begin
            for (int k = 0; k < 4; k++)
            begin
                if (cnt_q == 2'd0)
                begin
                    bin_re_q[k] <= term_re[k];
                    bin_im_q[k] <= term_im[k];
                end
                else
                begin
                    bin_re_q[k] <= bin_re_q[k] + term_re[k];
                    bin_im_q[k] <= bin_im_q[k] + term_im[k];
                end
            end
        end
    end

    // bin picked by the combine stage
    assign bin_re_o = bin_re_q[bin_sel_i];
    assign bin_im_o = bin_im_q[bin_sel_i];

endmodule

`default_nettype wire

//--- hw/fft8_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft8_macros.svh"

module fft8_core
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              in_valid_i,
    input  wire fft8_pkg::sample_t in_re_i,
    input  wire fft8_pkg::sample_t in_im_i,
    input  wire logic              out_ready_i,
    output logic                   in_ready_o,
    output logic                   out_valid_o,
    output fft8_pkg::spec_t        out_re_o,
    output fft8_pkg::spec_t        out_im_o
);

    import fft8_pkg::*;

    localparam logic [2:0] LAST_IDX = 3'(`FFT8_N - 1);

    fft_state_e state_q;
    logic [2:0] in_cnt_q;
    logic [2:0] out_cnt_q;
    logic       frame_full_q;
    logic       start_q;
    logic       out_valid_q;

    logic       in_fire;
    logic       out_fire;
    logic       even_valid;
    logic       odd_valid;
    logic       rd_en;
    logic [2:0] rd_addr;

    // kernel to combine
    kern_t      even_re;
    kern_t      even_im;
    kern_t      odd_re;
    kern_t      odd_im;
    logic [1:0] bin_sel;

    // combine to buffer
    logic       wr_en;
    logic [1:0] wr_addr;
    spec_t      low_re;
    spec_t      low_im;
    spec_t      high_re;
    spec_t      high_im;
    logic       combine_done;

    //////////////////////////////////////////////////
    // handshakes and input steering
    //////////////////////////////////////////////////

    // new samples only while collecting
    assign in_ready_o  = (state_q == COLLECT);
    assign out_valid_o = out_valid_q;
    assign in_fire     = in_valid_i && in_ready_o;
    assign out_fire    = out_valid_q && out_ready_i;

    // even index to the even kernel, odd index to the odd one
    assign even_valid = in_fire && !in_cnt_q[0];
    assign odd_valid  = in_fire && in_cnt_q[0];

    // prime fetches X0, each accepted bin fetches the next
    // no fetch after X7, the buffer just holds
    assign rd_en   = (state_q == PRIME) || (out_fire && (out_cnt_q != LAST_IDX));
    assign rd_addr = (state_q == PRIME) ? 3'd0 : out_cnt_q + 3'd1;

    //////////////////////////////////////////////////
    // phase controller
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q      <= COLLECT;
            in_cnt_q     <= '0;
            out_cnt_q    <= '0;
            frame_full_q <= 1'b0;
            start_q      <= 1'b0;
            out_valid_q  <= 1'b0;
        end
        else
        begin
            // start goes out one edge after the eighth sample
            frame_full_q <= in_fire && (in_cnt_q == LAST_IDX);
            start_q      <= frame_full_q;

            if (in_fire)
            begin
                in_cnt_q <= in_cnt_q + 3'd1;
            end
            // wraps back to 0 after X7
            if (out_fire)
            begin
                out_cnt_q <= out_cnt_q + 3'd1;
            end

            unique case (state_q)
                COLLECT:
                begin
                    if (in_fire && (in_cnt_q == LAST_IDX))
                    begin
                        state_q <= COMBINE;
                    end
                end
                COMBINE:
                begin
                    if (combine_done)
                    begin
                        state_q <= PRIME;
                    end
                end
                // X0 lands in the read register this cycle
                PRIME:
                begin
                    state_q     <= SEND;
                    out_valid_q <= 1'b1;
                end
                default:
                begin
                    if (out_fire && (out_cnt_q == LAST_IDX))
                    begin
                        state_q     <= COLLECT;
                        out_valid_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    fft4_accum u_even_kernel
    (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (even_valid),
        .sample_re_i    (in_re_i),
        .sample_im_i    (in_im_i),
        .bin_sel_i      (bin_sel),
        .bin_re_o       (even_re),
        .bin_im_o       (even_im)
    );

    fft4_accum u_odd_kernel
    (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (odd_valid),
        .sample_re_i    (in_re_i),
        .sample_im_i    (in_im_i),
        .bin_sel_i      (bin_sel),
        .bin_re_o       (odd_re),
        .bin_im_o       (odd_im)
    );

    twiddle_combine u_combine
    (
        .clk       (clk),
        .reset     (reset),
        .start_i   (start_q),
        .even_re_i (even_re),
        .even_im_i (even_im),
        .odd_re_i  (odd_re),
        .odd_im_i  (odd_im),
        .bin_sel_o (bin_sel),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .low_re_o  (low_re),
        .low_im_o  (low_im),
        .high_re_o (high_re),
        .high_im_o (high_im),
        .done_o    (combine_done)
    );

    // read port feeds the output directly
    spectrum_buffer u_buffer
    (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .low_re_i  (low_re),
        .low_im_i  (low_im),
        .high_re_i (high_re),
        .high_im_i (high_im),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_re_o   (out_re_o),
        .rd_im_o   (out_im_o)
    );

endmodule

`default_nettype wire

//--- hw/fft8_macros.svh
`ifndef FFT8_MACROS_SVH
`define FFT8_MACROS_SVH

// points per frame, one level of even/odd split
`define FFT8_N 8

// input sample component width
`define FFT8_IN_W 16

// 4-point kernel bins, two bits of growth over the input
`define FFT8_KERN_W 18

// spectrum width after the combine butterflies
`define FFT8_OUT_W 19

// twiddle constant 1/sqrt(2) in Q14
`define FFT8_TW_FRAC 14
`define FFT8_TW_COEF 11585

`endif

//--- hw/fft8_pkg.sv
`default_nettype none

`include "fft8_macros.svh"

package fft8_pkg;

    // signed components, real and imaginary travel separately
    typedef logic signed [`FFT8_IN_W-1:0]   sample_t;
    typedef logic signed [`FFT8_KERN_W-1:0] kern_t;
    typedef logic signed [`FFT8_OUT_W-1:0]  spec_t;

    // top controller phases
    typedef enum logic [1:0] {
        COLLECT = 2'd0,
        COMBINE = 2'd1,
        PRIME   = 2'd2,
        SEND    = 2'd3
    } fft_state_e;

    // rotation applied to odd bin k before the butterfly
    typedef enum logic [1:0] {
        TW_ONE     = 2'd0,
        TW_DIAG_DN = 2'd1,
        TW_MINUS_J = 2'd2,
        TW_DIAG_UP = 2'd3
    } tw_op_e;

endpackage

`default_nettype wire

//--- hw/spectrum_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module spectrum_buffer
(
    input  wire logic            clk,
    input  wire logic            wr_en_i,
    input  wire logic [1:0]      wr_addr_i,
    input  wire fft8_pkg::spec_t low_re_i,
    input  wire fft8_pkg::spec_t low_im_i,
    input  wire fft8_pkg::spec_t high_re_i,
    input  wire fft8_pkg::spec_t high_im_i,
    input  wire logic            rd_en_i,
    input  wire logic [2:0]      rd_addr_i,
    output fft8_pkg::spec_t      rd_re_o,
    output fft8_pkg::spec_t      rd_im_o
);

    import fft8_pkg::*;

    // bank 0 holds X0..X3, bank 1 holds X4..X7
    spec_t mem_re [2][4];
    spec_t mem_im [2][4];

    // both banks take their half of the butterfly together
    always_ff @(posedge clk)
    begin
        if (wr_en_i)
        begin
            mem_re[0][wr_addr_i] <= low_re_i;
            mem_im[0][wr_addr_i] <= low_im_i;
            mem_re[1][wr_addr_i] <= high_re_i;
            mem_im[1][wr_addr_i] <= high_im_i;
        end
    end

    // registered read, output holds while rd_en_i is low
    always_ff @(posedge clk)
    begin
        if (rd_en_i)
        begin
            rd_re_o <= mem_re[rd_addr_i[2]][rd_addr_i[1:0]];
            rd_im_o <= mem_im[rd_addr_i[2]][rd_addr_i[1:0]];
        end
    end

endmodule

`default_nettype wire

//--- hw/twiddle_combine.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft8_macros.svh"

module twiddle_combine
(
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            start_i,
    input  wire fft8_pkg::kern_t even_re_i,
    input  wire fft8_pkg::kern_t even_im_i,
    input  wire fft8_pkg::kern_t odd_re_i,
    input  wire fft8_pkg::kern_t odd_im_i,
    output logic [1:0]           bin_sel_o,
    output logic                 wr_en_o,
    output logic [1:0]           wr_addr_o,
    output fft8_pkg::spec_t      low_re_o,
    output fft8_pkg::spec_t      low_im_o,
    output fft8_pkg::spec_t      high_re_o,
    output fft8_pkg::spec_t      high_im_o,
    output logic                 done_o
);

    import fft8_pkg::*;

    // room for a 19 bit operand times the Q14 constant
    localparam int PROD_W = `FFT8_OUT_W + 16;
    localparam logic signed [15:0] TW_C = 16'(`FFT8_TW_COEF);

    //////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////

    logic       run_q;
    logic [1:0] cnt_q;
    logic       active;
    tw_op_e     op;

    // bin 0 is handled in the start cycle itself
    assign active    = start_i | run_q;
    assign bin_sel_o = cnt_q;

    always_comb
    begin
        unique case (cnt_q)
            2'd0:    op = TW_ONE;
            2'd1:    op = TW_DIAG_DN;
            2'd2:    op = TW_MINUS_J;
            default: op = TW_DIAG_UP;
        endcase
    end

    //////////////////////////////////////////////////
    // twiddle of the odd bin
    //////////////////////////////////////////////////

    spec_t odd_re;
    spec_t odd_im;
    spec_t even_re;
    spec_t even_im;
    spec_t sum_w;
    spec_t diff_w;
    logic signed [PROD_W-1:0] prod_sum;
    logic signed [PROD_W-1:0] prod_diff;
    logic signed [PROD_W-1:0] prod_nsum;
    spec_t tw_re;
    spec_t tw_im;

    assign odd_re  = spec_t'(odd_re_i);
    assign odd_im  = spec_t'(odd_im_i);
    assign even_re = spec_t'(even_re_i);
    assign even_im = spec_t'(even_im_i);

    // (a+b) and (b-a) feed both diagonal rotations
    assign sum_w     = odd_re + odd_im;
    assign diff_w    = odd_im - odd_re;
    assign prod_sum  = sum_w * TW_C;
    assign prod_diff = diff_w * TW_C;
    assign prod_nsum = -prod_sum;

    // bit slice at the fraction point is a floor shift
    always_comb
    begin
        unique case (op)
            TW_ONE:
            begin
                tw_re = odd_re;
                tw_im = odd_im;
            end
            TW_DIAG_DN:
            begin
                tw_re = prod_sum[`FFT8_TW_FRAC +: `FFT8_OUT_W];
                tw_im = prod_diff[`FFT8_TW_FRAC +: `FFT8_OUT_W];
            end
            TW_MINUS_J:
            begin
                tw_re = odd_im;
                tw_im = -odd_re;
            end
            default:
            begin
                tw_re = prod_diff[`FFT8_TW_FRAC +: `FFT8_OUT_W];
                tw_im = prod_nsum[`FFT8_TW_FRAC +: `FFT8_OUT_W];
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run_q   <= 1'b0;
            cnt_q   <= '0;
            wr_en_o <= 1'b0;
            done_o  <= 1'b0;
        end
        else
        begin
            wr_en_o <= active;
            // done rides along with the bin 3 write
            done_o  <= active && (cnt_q == 2'd3);
            if (active)
            begin
                cnt_q <= cnt_q + 2'd1;
                run_q <= (cnt_q != 2'd3);
            end
        end
    end

    // butterfly pair, X[k] low bank and X[k+4] high bank
    always_ff @(posedge clk)
    begin
        if (active)
        begin
            wr_addr_o <= cnt_q;
            low_re_o  <= even_re + tw_re;
            low_im_o  <= even_im + tw_im;
            high_re_o <= even_re - tw_re;
            high_im_o <= even_im - tw_im;
        end
    end

endmodule

`default_nettype wire

//--- verification/fft8_props.sv
`timescale 1ns/1ps
`default_nettype none

module fft8_props
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 in_valid_i,
    input  wire logic                 in_ready_i,
    input  wire logic                 out_valid_i,
    input  wire logic                 out_ready_i,
    input  wire fft8_pkg::spec_t      out_re_i,
    input  wire fft8_pkg::spec_t      out_im_i,
    input  wire logic [2:0]           in_cnt_i,
    input  wire fft8_pkg::fft_state_e state_i
);

    import fft8_pkg::*;

    // read by the testbench at the end of the run
    int unsigned violations = 0;

    logic last_in_fire;

    // eighth sample of the frame taken on this edge
    assign last_in_fire = in_valid_i && in_ready_i && (in_cnt_i == 3'd7);

    // stalled bin keeps its data and its valid
    assert property (@(posedge clk) disable iff (reset)
        (out_valid_i && !out_ready_i) |=>
            (out_valid_i && $stable(out_re_i) && $stable(out_im_i)))
    else
    begin
        $error("output bin changed while stalled");
        violations++;
    end

    // no input accepted while a spectrum is on its way out
    assert property (@(posedge clk) disable iff (reset)
        out_valid_i |-> (!in_ready_i && (state_i == SEND)))
    else
    begin
        $error("in_ready_o high while out_valid_o high");
        violations++;
    end

    // spectrum follows a full frame within 10 cycles
    assert property (@(posedge clk) disable iff (reset)
        last_in_fire |-> ##[1:10] out_valid_i)
    else
    begin
        $error("out_valid_o late after the eighth sample");
        violations++;
    end

endmodule

`default_nettype wire

//--- verification/fft8_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft8_macros.svh"

module fft8_tb;

    import fft8_pkg::*;

    // 200 cycles per test, 6 tests, plus the reset
    localparam int TIMEOUT_CYCLES = 6 * 200 + 16;

    logic    clk;
    logic    reset;
    logic    in_valid_i;
    sample_t in_re_i;
    sample_t in_im_i;
    logic    out_ready_i;
    logic    in_ready_o;
    logic    out_valid_o;
    spec_t   out_re_o;
    spec_t   out_im_o;

    integer seed = 32'h5cea_dcc7;
    int     cycles = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     err_mark = 0;

    // current frame and its expected spectrum
    int x_re [`FFT8_N];
    int x_im [`FFT8_N];
    int exp_re [`FFT8_N];
    int exp_im [`FFT8_N];

    fft8_core u_fft8_core
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid_i  (in_valid_i),
        .in_re_i     (in_re_i),
        .in_im_i     (in_im_i),
        .out_ready_i (out_ready_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_re_o    (out_re_o),
        .out_im_o    (out_im_o)
    );

    bind fft8_core fft8_props u_props
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid_i  (in_valid_i),
        .in_ready_i  (in_ready_o),
        .out_valid_i (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_re_i    (out_re_o),
        .out_im_i    (out_im_o),
        .in_cnt_i    (in_cnt_q),
        .state_i     (state_q)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: DUT did not finish the tests in %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // sample times W4^p, p = n*k mod 4
    function automatic longint rot_re(input int p, input longint a, input longint b);
        case (p)
            0:       return a;
            1:       return b;
            2:       return -a;
            default: return -b;
        endcase
    endfunction

    function automatic longint rot_im(input int p, input longint a, input longint b);
        case (p)
            0:       return b;
            1:       return -a;
            2:       return -b;
            default: return a;
        endcase
    endfunction

    task automatic build_model();
        longint e_re;
        longint e_im;
        longint a;
        longint b;
        longint t_re;
        longint t_im;
        longint c;
        tw_op_e op;
        c = `FFT8_TW_COEF;
        for (int k = 0; k < 4; k++)
        begin
            e_re = 0;
            e_im = 0;
            a = 0;
            b = 0;
            // exact 4-point DFT of even and odd samples
            for (int m = 0; m < 4; m++)
            begin
                e_re += rot_re((m * k) % 4, x_re[2*m], x_im[2*m]);
                e_im += rot_im((m * k) % 4, x_re[2*m], x_im[2*m]);
                a += rot_re((m * k) % 4, x_re[2*m+1], x_im[2*m+1]);
                b += rot_im((m * k) % 4, x_re[2*m+1], x_im[2*m+1]);
            end
            // twiddle with floor shift
            op = tw_op_e'(k);
            case (op)
                TW_ONE:
                begin
                    t_re = a;
                    t_im = b;
                end
                TW_DIAG_DN:
                begin
                    t_re = ((a + b) * c) >>> `FFT8_TW_FRAC;
                    t_im = ((b - a) * c) >>> `FFT8_TW_FRAC;
                end
                TW_MINUS_J:
                begin
                    t_re = b;
                    t_im = -a;
                end
                default:
                begin
                    t_re = ((b - a) * c) >>> `FFT8_TW_FRAC;
                    t_im = (-(a + b) * c) >>> `FFT8_TW_FRAC;
                end
            endcase
            exp_re[k]   = int'(e_re + t_re);
            exp_im[k]   = int'(e_im + t_im);
            exp_re[k+4] = int'(e_re - t_re);
            exp_im[k+4] = int'(e_im - t_im);
        end
    endtask

    //////////////////////////////////////////////////
    // drivers and checks
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input int got, input int want);
        checks++;
        assert (got == want)
        else
        begin
            $display("[FAIL] %0t ns: %s = %0d, expected %0d", $time, name, got, want);
            errors++;
        end
    endtask

    // random idle cycles of up to gap_max before each sample
    task automatic drive_frame(input int gap_max);
        int  gaps;
        bit  taken;
        for (int n = 0; n < `FFT8_N; n++)
        begin
            gaps = (gap_max > 0) ? ({$random(seed)} % (gap_max + 1)) : 0;
            in_valid_i = 1'b0;
            repeat (gaps)
            begin
                @(posedge clk);
                #1;
            end
            in_valid_i = 1'b1;
            in_re_i    = sample_t'(x_re[n]);
            in_im_i    = sample_t'(x_im[n]);
            taken      = 1'b0;
            // ready is stable from here to the next edge
            while (!taken)
            begin
                taken = in_ready_o;
                @(posedge clk);
                #1;
            end
        end
        in_valid_i = 1'b0;
    endtask

    task automatic receive_bins(input bit throttle);
        bit done;
        for (int i = 0; i < `FFT8_N; i++)
        begin
            done = 1'b0;
            while (!done)
            begin
                out_ready_i = throttle ? 1'($random(seed)) : 1'b1;
                if (out_valid_o && out_ready_i)
                begin
                    check_value($sformatf("out_re_o X%0d", i), out_re_o, exp_re[i]);
                    check_value($sformatf("out_im_o X%0d", i), out_im_o, exp_im[i]);
                    done = 1'b1;
                end
                @(posedge clk);
                #1;
            end
        end
        out_ready_i = 1'b1;
    endtask

    task automatic run_frame(input int gap_max, input bit throttle, input bit stuff);
        drive_frame(gap_max);
        // junk offered while the core is busy, must be ignored
        if (stuff)
        begin
            in_valid_i = 1'b1;
            in_re_i    = sample_t'($random(seed));
            in_im_i    = sample_t'($random(seed));
            while (!out_valid_o)
            begin
                @(posedge clk);
                #1;
            end
            in_valid_i = 1'b0;
        end
        receive_bins(throttle);
    endtask

    task automatic random_frame();
        for (int n = 0; n < `FFT8_N; n++)
        begin
            x_re[n] = $random(seed) % 8001;
            x_im[n] = $random(seed) % 8001;
        end
        build_model();
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == err_mark)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic reset_state_test();
        check_value("in_ready_o", in_ready_o, 1);
        check_value("out_valid_o", out_valid_o, 0);
        report_test("reset state");
    endtask

    // flat spectrum of height 1000
    task automatic impulse_test();
        for (int n = 0; n < `FFT8_N; n++)
        begin
            x_re[n]   = (n == 0) ? 1000 : 0;
            x_im[n]   = 0;
            exp_re[n] = 1000;
            exp_im[n] = 0;
        end
        run_frame(0, 1'b0, 1'b0);
        report_test("impulse");
    endtask

    // all energy in X0
    task automatic constant_test();
        for (int n = 0; n < `FFT8_N; n++)
        begin
            x_re[n]   = 1234;
            x_im[n]   = -567;
            exp_re[n] = (n == 0) ? 8 * 1234 : 0;
            exp_im[n] = (n == 0) ? -8 * 567 : 0;
        end
        run_frame(0, 1'b0, 1'b0);
        report_test("constant");
    endtask

    task automatic random_frames_test();
        repeat (4)
        begin
            random_frame();
            run_frame(0, 1'b0, 1'b0);
        end
        report_test("random frames");
    endtask

    task automatic backpressure_test();
        repeat (2)
        begin
            random_frame();
            run_frame(0, 1'b1, 1'b0);
        end
        report_test("output back-pressure");
    endtask

    task automatic back_to_back_test();
        repeat (3)
        begin
            random_frame();
            run_frame(3, 1'b0, 1'b1);
        end
        report_test("back-to-back frames");
    endtask

    initial
    begin
        int total;
        reset       = 1'b1;
        in_valid_i  = 1'b0;
        in_re_i     = '0;
        in_im_i     = '0;
        out_ready_i = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_state_test();
        impulse_test();
        constant_test();
        random_frames_test();
        backpressure_test();
        back_to_back_test();

        total = errors + u_fft8_core.u_props.violations;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, checks, errors, u_fft8_core.u_props.violations);
        if (total == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
